/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int DATA_W = 16; // width of a data word and of an instruction.
	localparam int REG_COUNT = 8;
	localparam int REG_AW = $clog2(REG_COUNT);
	localparam int IMEM_DEPTH = 64;
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);
	localparam int DMEM_DEPTH = 64;
	localparam int DMEM_AW = $clog2(DMEM_DEPTH);
	localparam int IMM_W = 6;
	localparam int SHAMT_W = 4; // shifts use only the low bits of the immediate.
	localparam int FLAG_W = 4;

	// Instruction fields, lowest bit of each.
	localparam int OPC_LSB = 12;
	localparam int RD_LSB = 9;
	localparam int RS_LSB = 6;
	localparam int IMM_LSB = 0;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [IMEM_AW-1:0] pc_t;
	typedef logic [DMEM_AW-1:0] dmem_addr_t;
	typedef logic [FLAG_W-1:0] flags_t;

	localparam int FLAG_Z = 0;
	localparam int FLAG_N = 1;
	localparam int FLAG_C = 2;
	localparam int FLAG_V = 3; // signed overflow.

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR = 4'd4,
		OP_NOT = 4'd5,
		OP_SHL = 4'd6,
		OP_SHR = 4'd7,
		OP_LDM = 4'd8,
		OP_LDD = 4'd9,
		OP_STD = 4'd10,
		OP_OUT = 4'd11,
		OP_SETC = 4'd12,
		OP_CLRC = 4'd13
	} opcode_t; // codes 14 and 15 are decoded as NOP.

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module fetch_stage (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire imem_we,
	input wire cpu_pkg::pc_t imem_addr,
	input wire cpu_pkg::word_t imem_wdata,
	output cpu_pkg::word_t if_instr
);

	cpu_pkg::word_t imem [cpu_pkg::IMEM_DEPTH];
	cpu_pkg::pc_t pc;
	logic halted; // set once the last address has been fetched.

	// load port, open in every cycle.
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// The PC stops at the end of memory, after that only NOPs enter the pipeline.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			halted <= 1'b0;
			if_instr <= '0; // the all-zero word decodes as NOP.
		end else if (!stall) begin
			if (halted) begin
				if_instr <= '0;
			end else begin
				if_instr <= imem[pc];
				pc <= pc + 1'b1;
				halted <= (pc == cpu_pkg::pc_t'(cpu_pkg::IMEM_DEPTH - 1));
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::word_t if_instr,
	input wire cpu_pkg::reg_addr_t wb_rd,
	input wire cpu_pkg::word_t wb_val,
	input wire wb_reg_write,
	output logic stall,
	output cpu_pkg::opcode_t id_op,
	output cpu_pkg::reg_addr_t id_rd,
	output cpu_pkg::reg_addr_t id_rs,
	output cpu_pkg::word_t id_rd_val,
	output cpu_pkg::word_t id_rs_val,
	output logic [cpu_pkg::IMM_W-1:0] id_imm,
	output logic id_reg_write,
	output logic id_mem_read,
	output logic id_mem_write,
	output logic id_out_en
);

	cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

	cpu_pkg::opcode_t op_raw;
	cpu_pkg::opcode_t op_dec;
	cpu_pkg::reg_addr_t instr_rd;
	cpu_pkg::reg_addr_t instr_rs;
	logic [cpu_pkg::IMM_W-1:0] instr_imm;
	cpu_pkg::word_t rd_val;
	cpu_pkg::word_t rs_val;
	logic uses_rd;
	logic uses_rs;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic out_en;

	assign op_raw = cpu_pkg::opcode_t'(if_instr[cpu_pkg::OPC_LSB +: 4]);
	assign instr_rd = if_instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_AW];
	assign instr_rs = if_instr[cpu_pkg::RS_LSB +: cpu_pkg::REG_AW];
	assign instr_imm = if_instr[cpu_pkg::IMM_LSB +: cpu_pkg::IMM_W];

	always_comb begin
		op_dec = op_raw;
		uses_rd = 1'b0;
		uses_rs = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		out_en = 1'b0;
		case (op_raw)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR: begin
				uses_rd = 1'b1;
				uses_rs = 1'b1;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_NOT, cpu_pkg::OP_SHL, cpu_pkg::OP_SHR: begin
				uses_rd = 1'b1;
				reg_write = 1'b1;
			end
			cpu_pkg::OP_LDM: begin
				reg_write = 1'b1;
			end
			cpu_pkg::OP_LDD: begin
				uses_rs = 1'b1; // Rs holds the address.
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			cpu_pkg::OP_STD: begin
				uses_rd = 1'b1;
				uses_rs = 1'b1;
				mem_write = 1'b1;
			end
			cpu_pkg::OP_OUT: begin
				uses_rd = 1'b1;
				out_en = 1'b1;
			end
			cpu_pkg::OP_NOP, cpu_pkg::OP_SETC, cpu_pkg::OP_CLRC: begin
				op_dec = op_raw; // flag ops carry no register traffic.
			end
			default: begin
				op_dec = cpu_pkg::OP_NOP; // unused codes become NOP here.
			end
		endcase
	end

	// A load in ID/EX cannot forward its data yet, so a reader right behind it waits a cycle.
	assign stall = id_mem_read &&
		((uses_rd && (instr_rd == id_rd)) || (uses_rs && (instr_rs == id_rd)));

	// register file with write-through on the read side.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_reg_write) begin
			regs[wb_rd] <= wb_val;
		end
	end

	assign rd_val = (wb_reg_write && (wb_rd == instr_rd)) ? wb_val : regs[instr_rd];
	assign rs_val = (wb_reg_write && (wb_rd == instr_rs)) ? wb_val : regs[instr_rs];

	always_ff @(posedge clk) begin
		if (!rst_n || stall) begin
			id_op <= cpu_pkg::OP_NOP; // bubble on stall.
			id_reg_write <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_out_en <= 1'b0;
		end else begin
			id_op <= op_dec;
			id_reg_write <= reg_write;
			id_mem_read <= mem_read;
			id_mem_write <= mem_write;
			id_out_en <= out_en;
		end
	end

	always_ff @(posedge clk) begin
		id_rd <= instr_rd;
		id_rs <= instr_rs;
		id_rd_val <= rd_val;
		id_rs_val <= rs_val;
		id_imm <= instr_imm;
	end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module execute_stage (
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::opcode_t id_op,
	input wire cpu_pkg::reg_addr_t id_rd,
	input wire cpu_pkg::reg_addr_t id_rs,
	input wire cpu_pkg::word_t id_rd_val,
	input wire cpu_pkg::word_t id_rs_val,
	input wire [cpu_pkg::IMM_W-1:0] id_imm,
	input wire id_reg_write,
	input wire id_mem_read,
	input wire id_mem_write,
	input wire id_out_en,
	input wire cpu_pkg::reg_addr_t wb_rd,
	input wire cpu_pkg::word_t wb_val,
	input wire wb_reg_write,
	output cpu_pkg::flags_t flags,
	output cpu_pkg::word_t ex_result,
	output cpu_pkg::word_t ex_store_val,
	output cpu_pkg::dmem_addr_t ex_addr,
	output cpu_pkg::reg_addr_t ex_rd,
	output logic ex_reg_write,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_out_en
);

	cpu_pkg::word_t op_a; // the Rd operand.
	cpu_pkg::word_t op_b; // the Rs operand.
	cpu_pkg::word_t alu_res;
	cpu_pkg::word_t sub_res;
	logic [cpu_pkg::DATA_W:0] add_full;
	cpu_pkg::flags_t flags_nxt;

	// EX/MEM is newer than MEM/WB, so it is checked first.
	assign op_a = (ex_reg_write && (ex_rd == id_rd)) ? ex_result :
		(wb_reg_write && (wb_rd == id_rd)) ? wb_val : id_rd_val;
	assign op_b = (ex_reg_write && (ex_rd == id_rs)) ? ex_result :
		(wb_reg_write && (wb_rd == id_rs)) ? wb_val : id_rs_val;

	assign add_full = {1'b0, op_a} + {1'b0, op_b};
	assign sub_res = op_a - op_b;

	always_comb begin
		alu_res = op_a; // OUT and STD pass Rd through.
		flags_nxt = flags;
		case (id_op)
			cpu_pkg::OP_ADD: begin
				alu_res = add_full[cpu_pkg::DATA_W-1:0];
				flags_nxt[cpu_pkg::FLAG_C] = add_full[cpu_pkg::DATA_W];
				flags_nxt[cpu_pkg::FLAG_V] = (op_a[cpu_pkg::DATA_W-1] == op_b[cpu_pkg::DATA_W-1]) &&
					(alu_res[cpu_pkg::DATA_W-1] != op_a[cpu_pkg::DATA_W-1]);
			end
			cpu_pkg::OP_SUB: begin
				alu_res = sub_res;
				flags_nxt[cpu_pkg::FLAG_C] = (op_a < op_b); // borrow.
				flags_nxt[cpu_pkg::FLAG_V] = (op_a[cpu_pkg::DATA_W-1] != op_b[cpu_pkg::DATA_W-1]) &&
					(alu_res[cpu_pkg::DATA_W-1] != op_a[cpu_pkg::DATA_W-1]);
			end
			cpu_pkg::OP_AND: alu_res = op_a & op_b;
			cpu_pkg::OP_OR: alu_res = op_a | op_b;
			cpu_pkg::OP_NOT: alu_res = ~op_a;
			cpu_pkg::OP_SHL: alu_res = op_a << id_imm[cpu_pkg::SHAMT_W-1:0];
			cpu_pkg::OP_SHR: alu_res = op_a >> id_imm[cpu_pkg::SHAMT_W-1:0];
			cpu_pkg::OP_LDM: alu_res = {{(cpu_pkg::DATA_W - cpu_pkg::IMM_W){1'b0}}, id_imm};
			cpu_pkg::OP_SETC: flags_nxt[cpu_pkg::FLAG_C] = 1'b1;
			cpu_pkg::OP_CLRC: flags_nxt[cpu_pkg::FLAG_C] = 1'b0;
			default: alu_res = op_a;
		endcase
		// Z and N follow the result of ADD, SUB, AND, OR and NOT.
		case (id_op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
			cpu_pkg::OP_NOT: begin
				flags_nxt[cpu_pkg::FLAG_Z] = (alu_res == '0);
				flags_nxt[cpu_pkg::FLAG_N] = alu_res[cpu_pkg::DATA_W-1];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_out_en <= 1'b0;
		end else begin
			flags <= flags_nxt;
			ex_reg_write <= id_reg_write;
			ex_mem_read <= id_mem_read;
			ex_mem_write <= id_mem_write;
			ex_out_en <= id_out_en;
		end
	end

	always_ff @(posedge clk) begin
		ex_result <= alu_res;
		ex_store_val <= op_a; // STD writes Rd.
		ex_addr <= op_b[cpu_pkg::DMEM_AW-1:0]; // the address is the low bits of Rs.
		ex_rd <= id_rd;
	end

endmodule

`default_nettype wire

/* hdl/memory_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module memory_stage (
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::word_t ex_result,
	input wire cpu_pkg::word_t ex_store_val,
	input wire cpu_pkg::dmem_addr_t ex_addr,
	input wire cpu_pkg::reg_addr_t ex_rd,
	input wire ex_reg_write,
	input wire ex_mem_read,
	input wire ex_mem_write,
	input wire ex_out_en,
	output cpu_pkg::reg_addr_t wb_rd,
	output cpu_pkg::word_t wb_val,
	output logic wb_reg_write,
	output logic out_valid,
	output cpu_pkg::word_t out_data
);

	cpu_pkg::word_t dmem [cpu_pkg::DMEM_DEPTH];
	cpu_pkg::word_t load_data;

	assign load_data = dmem[ex_addr]; // asynchronous read, registered into MEM/WB.

	always_ff @(posedge clk) begin
		if (ex_mem_write) begin
			dmem[ex_addr] <= ex_store_val;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_reg_write <= 1'b0;
			out_valid <= 1'b0;
			out_data <= '0;
		end else begin
			wb_reg_write <= ex_reg_write;
			out_valid <= ex_out_en; // a single-cycle strobe per OUT.
			if (ex_out_en) begin
				out_data <= ex_result; // holds the last value between OUTs.
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= ex_rd;
		wb_val <= ex_mem_read ? load_data : ex_result;
	end

endmodule

`default_nettype wire

/* hdl/processor.sv */
`default_nettype none
`timescale 1ns/1ns

module processor (
	input wire clk,
	input wire rst_n,
	input wire imem_we,
	input wire cpu_pkg::pc_t imem_addr,
	input wire cpu_pkg::word_t imem_wdata,
	output logic out_valid,
	output cpu_pkg::word_t out_data,
	output cpu_pkg::flags_t flags
);

	cpu_pkg::word_t if_instr; // IF/ID.
	logic stall;

	cpu_pkg::opcode_t id_op; // ID/EX.
	cpu_pkg::reg_addr_t id_rd;
	cpu_pkg::reg_addr_t id_rs;
	cpu_pkg::word_t id_rd_val;
	cpu_pkg::word_t id_rs_val;
	logic [cpu_pkg::IMM_W-1:0] id_imm;
	logic id_reg_write;
	logic id_mem_read;
	logic id_mem_write;
	logic id_out_en;

	cpu_pkg::word_t ex_result; // EX/MEM.
	cpu_pkg::word_t ex_store_val;
	cpu_pkg::dmem_addr_t ex_addr;
	cpu_pkg::reg_addr_t ex_rd;
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_out_en;

	cpu_pkg::reg_addr_t wb_rd; // MEM/WB.
	cpu_pkg::word_t wb_val;
	logic wb_reg_write;

	fetch_stage fetch_i (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.if_instr(if_instr)
	);

	decode_stage decode_i (
		.clk(clk),
		.rst_n(rst_n),
		.if_instr(if_instr),
		.wb_rd(wb_rd),
		.wb_val(wb_val),
		.wb_reg_write(wb_reg_write),
		.stall(stall),
		.id_op(id_op),
		.id_rd(id_rd),
		.id_rs(id_rs),
		.id_rd_val(id_rd_val),
		.id_rs_val(id_rs_val),
		.id_imm(id_imm),
		.id_reg_write(id_reg_write),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_out_en(id_out_en)
	);

	execute_stage execute_i (
		.clk(clk),
		.rst_n(rst_n),
		.id_op(id_op),
		.id_rd(id_rd),
		.id_rs(id_rs),
		.id_rd_val(id_rd_val),
		.id_rs_val(id_rs_val),
		.id_imm(id_imm),
		.id_reg_write(id_reg_write),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_out_en(id_out_en),
		.wb_rd(wb_rd),
		.wb_val(wb_val),
		.wb_reg_write(wb_reg_write),
		.flags(flags),
		.ex_result(ex_result),
		.ex_store_val(ex_store_val),
		.ex_addr(ex_addr),
		.ex_rd(ex_rd),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_out_en(ex_out_en)
	);

	memory_stage memory_i (
		.clk(clk),
		.rst_n(rst_n),
		.ex_result(ex_result),
		.ex_store_val(ex_store_val),
		.ex_addr(ex_addr),
		.ex_rd(ex_rd),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_out_en(ex_out_en),
		.wb_rd(wb_rd),
		.wb_val(wb_val),
		.wb_reg_write(wb_reg_write),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

/* testbench/processor_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module processor_tb;

	localparam int NUM_TESTS = 7;
	localparam int PROG_MAX = 16;
	localparam int OUT_MAX = 8;
	localparam int RUN_CYCLES = cpu_pkg::IMEM_DEPTH + 8;
	// Each test loads one memory length and then runs about one memory length.
	localparam int CYCLE_LIMIT = NUM_TESTS * (2 * cpu_pkg::IMEM_DEPTH + 16) + 32;

	logic clk;
	logic rst_n;
	logic imem_we;
	cpu_pkg::pc_t imem_addr;
	cpu_pkg::word_t imem_wdata;
	logic out_valid;
	cpu_pkg::word_t out_data;
	cpu_pkg::flags_t flags;

	cpu_pkg::word_t prog_tbl [NUM_TESTS][PROG_MAX];
	int prog_len [NUM_TESTS];
	cpu_pkg::word_t out_tbl [NUM_TESTS][OUT_MAX];
	int out_count [NUM_TESTS];
	cpu_pkg::flags_t flags_tbl [NUM_TESTS];
	cpu_pkg::word_t seen [$]; // OUT values in the order they appeared.
	int test_errors;
	int passed;
	int failed;
	int cycle_count = 0;

	processor processor_i (
		.clk(clk),
		.rst_n(rst_n),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.out_valid(out_valid),
		.out_data(out_data),
		.flags(flags)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("The run reached its limit of %0d cycles before the tests ended.", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic append_instr(input int t, input cpu_pkg::opcode_t op,
		input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs, input logic [5:0] imm);
		prog_tbl[t][prog_len[t]] = {op, rd, rs, imm};
		prog_len[t]++;
	endtask

	task automatic expect_out(input int t, input cpu_pkg::word_t value);
		out_tbl[t][out_count[t]] = value;
		out_count[t]++;
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t got,
		input cpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%04h, expected 0x%04h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_flags(input string name, input cpu_pkg::flags_t got,
		input cpu_pkg::flags_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp);
			test_errors++;
		end
	endtask

	// LDM, SHL and ADD chains on random immediates, with sums and flags worked out here.
	task automatic build_random_test(input int t);
		logic [31:0] rnd;
		logic [5:0] a_imm;
		logic [5:0] b_imm;
		logic [5:0] c_imm;
		logic [3:0] a_sh;
		logic [3:0] b_sh;
		cpu_pkg::word_t r1;
		cpu_pkg::word_t r2;
		cpu_pkg::word_t r3;
		logic [16:0] sum; // one bit wider to keep the carry.
		int ssum; // the same sum taken as signed numbers.
		cpu_pkg::flags_t f;
		rnd = $urandom;
		a_imm = rnd[5:0];
		b_imm = rnd[11:6];
		c_imm = rnd[17:12];
		a_sh = rnd[21:18];
		b_sh = rnd[25:22];
		append_instr(t, cpu_pkg::OP_LDM, 3'd1, 3'd0, a_imm);
		append_instr(t, cpu_pkg::OP_SHL, 3'd1, 3'd0, {2'b00, a_sh});
		append_instr(t, cpu_pkg::OP_LDM, 3'd2, 3'd0, b_imm);
		append_instr(t, cpu_pkg::OP_SHL, 3'd2, 3'd0, {2'b00, b_sh});
		append_instr(t, cpu_pkg::OP_ADD, 3'd1, 3'd2, 6'h00);
		append_instr(t, cpu_pkg::OP_OUT, 3'd1, 3'd0, 6'h00);
		append_instr(t, cpu_pkg::OP_LDM, 3'd3, 3'd0, c_imm);
		append_instr(t, cpu_pkg::OP_ADD, 3'd3, 3'd1, 6'h00);
		append_instr(t, cpu_pkg::OP_OUT, 3'd3, 3'd0, 6'h00);
		r1 = {10'd0, a_imm};
		r1 = r1 << a_sh;
		r2 = {10'd0, b_imm};
		r2 = r2 << b_sh;
		sum = {1'b0, r1} + {1'b0, r2};
		r1 = sum[15:0];
		expect_out(t, r1);
		r3 = {10'd0, c_imm};
		sum = {1'b0, r3} + {1'b0, r1};
		expect_out(t, sum[15:0]);
		ssum = int'($signed(r3)) + int'($signed(r1));
		f = '0;
		f[cpu_pkg::FLAG_Z] = (sum[15:0] == 16'h0000);
		f[cpu_pkg::FLAG_N] = sum[15];
		f[cpu_pkg::FLAG_C] = sum[16];
		f[cpu_pkg::FLAG_V] = (ssum > 32767) || (ssum < -32768);
		flags_tbl[t] = f;
	endtask

	task automatic build_tests();
		for (int t = 0; t < NUM_TESTS; t++) begin
			prog_len[t] = 0;
			out_count[t] = 0;
		end
		append_instr(0, cpu_pkg::OP_LDM, 3'd1, 3'd0, 6'h05); // immediates come out in order.
		append_instr(0, cpu_pkg::OP_LDM, 3'd2, 3'd0, 6'h3f);
		append_instr(0, cpu_pkg::OP_LDM, 3'd3, 3'd0, 6'h2a);
		append_instr(0, cpu_pkg::OP_LDM, 3'd7, 3'd0, 6'h01);
		append_instr(0, cpu_pkg::OP_OUT, 3'd1, 3'd0, 6'h00);
		append_instr(0, cpu_pkg::OP_OUT, 3'd2, 3'd0, 6'h00);
		append_instr(0, cpu_pkg::OP_OUT, 3'd3, 3'd0, 6'h00);
		append_instr(0, cpu_pkg::OP_OUT, 3'd7, 3'd0, 6'h00);
		expect_out(0, 16'h0005);
		expect_out(0, 16'h003f);
		expect_out(0, 16'h002a);
		expect_out(0, 16'h0001);
		flags_tbl[0] = 4'h0;
		append_instr(1, cpu_pkg::OP_LDM, 3'd1, 3'd0, 6'h30); // every op reads the one before.
		append_instr(1, cpu_pkg::OP_LDM, 3'd2, 3'd0, 6'h05);
		append_instr(1, cpu_pkg::OP_ADD, 3'd1, 3'd2, 6'h00);
		append_instr(1, cpu_pkg::OP_SUB, 3'd1, 3'd2, 6'h00);
		append_instr(1, cpu_pkg::OP_OUT, 3'd1, 3'd0, 6'h00);
		append_instr(1, cpu_pkg::OP_AND, 3'd1, 3'd2, 6'h00);
		append_instr(1, cpu_pkg::OP_OR, 3'd1, 3'd2, 6'h00);
		append_instr(1, cpu_pkg::OP_OUT, 3'd1, 3'd0, 6'h00);
		append_instr(1, cpu_pkg::OP_NOT, 3'd1, 3'd0, 6'h00);
		append_instr(1, cpu_pkg::OP_OUT, 3'd1, 3'd0, 6'h00);
		append_instr(1, cpu_pkg::OP_SHL, 3'd1, 3'd0, 6'h04);
		append_instr(1, cpu_pkg::OP_SHR, 3'd1, 3'd0, 6'h02);
		append_instr(1, cpu_pkg::OP_OUT, 3'd1, 3'd0, 6'h00);
		expect_out(1, 16'h0030);
		expect_out(1, 16'h0005);
		expect_out(1, 16'hfffa);
		expect_out(1, 16'h3fe8);
		flags_tbl[1] = 4'h2; // N from the NOT, C and V from the SUB.
		append_instr(2, cpu_pkg::OP_LDM, 3'd1, 3'd0, 6'h2b);
		append_instr(2, cpu_pkg::OP_LDM, 3'd2, 3'd0, 6'h0a);
		append_instr(2, cpu_pkg::OP_STD, 3'd1, 3'd2, 6'h00);
		append_instr(2, cpu_pkg::OP_LDD, 3'd3, 3'd2, 6'h00);
		append_instr(2, cpu_pkg::OP_ADD, 3'd3, 3'd3, 6'h00); // load-use stall.
		append_instr(2, cpu_pkg::OP_OUT, 3'd3, 3'd0, 6'h00);
		append_instr(2, cpu_pkg::OP_LDD, 3'd4, 3'd2, 6'h00);
		append_instr(2, cpu_pkg::OP_OUT, 3'd4, 3'd0, 6'h00);
		expect_out(2, 16'h0056);
		expect_out(2, 16'h002b);
		flags_tbl[2] = 4'h0;
		append_instr(3, cpu_pkg::OP_LDM, 3'd1, 3'd0, 6'h01);
		append_instr(3, cpu_pkg::OP_SHL, 3'd1, 3'd0, 6'h0f);
		append_instr(3, cpu_pkg::OP_NOT, 3'd1, 3'd0, 6'h00);
		append_instr(3, cpu_pkg::OP_LDM, 3'd2, 3'd0, 6'h01);
		append_instr(3, cpu_pkg::OP_ADD, 3'd1, 3'd2, 6'h00); // 0x7fff + 1 overflows.
		append_instr(3, cpu_pkg::OP_OUT, 3'd1, 3'd0, 6'h00);
		append_instr(3, cpu_pkg::OP_SUB, 3'd2, 3'd1, 6'h00); // 1 - 0x8000 borrows.
		append_instr(3, cpu_pkg::OP_OUT, 3'd2, 3'd0, 6'h00);
		append_instr(3, cpu_pkg::OP_LDM, 3'd3, 3'd0, 6'h00);
		append_instr(3, cpu_pkg::OP_OR, 3'd3, 3'd3, 6'h00);
		append_instr(3, cpu_pkg::OP_CLRC, 3'd0, 3'd0, 6'h00);
		expect_out(3, 16'h8000);
		expect_out(3, 16'h8001);
		flags_tbl[3] = 4'h9; // V kept from the SUB, Z from the OR.
		for (int r = 0; r < cpu_pkg::REG_COUNT; r++) begin
			append_instr(4, cpu_pkg::OP_OUT, cpu_pkg::reg_addr_t'(r), 3'd0, 6'h00);
			expect_out(4, 16'h0000);
		end
		append_instr(4, cpu_pkg::OP_SETC, 3'd0, 3'd0, 6'h00);
		flags_tbl[4] = 4'h4;
		build_random_test(5);
		build_random_test(6);
	endtask

	task automatic reset_and_load(input int t);
		test_errors = 0;
		@(posedge clk);
		#5;
		rst_n = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#5;
			check_bit("out_valid in reset", out_valid, 1'b0);
		end
		// The whole memory is written so that nothing of the last program is fetched.
		for (int a = 0; a < cpu_pkg::IMEM_DEPTH; a++) begin
			imem_we = 1'b1;
			imem_addr = cpu_pkg::pc_t'(a);
			if (a < prog_len[t]) begin
				imem_wdata = prog_tbl[t][a];
			end else begin
				imem_wdata = '0;
			end
			@(posedge clk);
			#5;
			check_bit("out_valid in reset", out_valid, 1'b0);
		end
		imem_we = 1'b0;
		rst_n = 1'b1;
	endtask

	task automatic run_program();
		seen.delete();
		for (int c = 0; c < RUN_CYCLES; c++) begin
			@(posedge clk);
			#5;
			if (out_valid) begin
				seen.push_back(out_data);
			end
		end
	endtask

	task automatic check_results(input int t);
		if (seen.size() != out_count[t]) begin
			$display("Test %0d gave %0d OUT values where %0d were expected.",
				t, seen.size(), out_count[t]);
			test_errors++;
		end
		for (int i = 0; i < out_count[t]; i++) begin
			if (i < seen.size()) begin
				check_word($sformatf("out_data[%0d]", i), seen[i], out_tbl[t][i]);
			end
		end
		check_flags("flags", flags, flags_tbl[t]);
		if (test_errors == 0) begin
			$display("Test %0d passed.", t);
			passed++;
		end else begin
			$display("Test %0d failed with %0d errors.", t, test_errors);
			failed++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		passed = 0;
		failed = 0;
		void'($urandom(32'h368a_955b));
		build_tests();
		for (int t = 0; t < NUM_TESTS; t++) begin
			reset_and_load(t);
			run_program();
			check_results(t);
		end
		$display("%0d tests passed, %0d tests failed.", passed, failed);
		if (failed == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/processor.sv
testbench/processor_tb.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary -j 0 --timescale 1ns/1ns --top-module processor_tb \
		-f sources.f -o processor_sim
	@out="$$(./obj_dir/processor_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module processor_tb \
		-f sources.f

clean:
	rm -rf obj_dir
